// ==== filelist.f ====
arm_isa_pkg.sv
ctrl_pkg.sv
ctrl_sequencer.sv
instr_decoder.sv
issue_stage.sv
control_unit.sv
tb_clock_gen.sv
tb_control_unit.sv

// ==== tb_control_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_control_unit
    import arm_isa_pkg::*;
();

    localparam int num_instr   = 200;
    localparam int cycle_limit = 1000;  // 16 reset + 3 per instruction, about 620

    logic       clk;
    logic       reset;
    word_t      instr_in;
    word_t      b_bus_in;
    logic       control_reset;
    logic       update_address;
    logic       pc_write_en;
    reg_idx_t   reg_read_a_sel;
    reg_idx_t   reg_read_b_sel;
    reg_idx_t   reg_write_sel;
    logic       reg_read_b_en;
    logic       reg_write_en;
    logic       cpsr_write_en;
    barrel_op_e barrel_op_sel;
    word_t      barrel_shift_val;
    alu_op_e    alu_op_sel;
    word_t      immediate_value;
    logic       imm_output_en;

    word_t instr_list [0:num_instr];    // last slot only fills the final fetch
    word_t bbus_list [0:num_instr-1];
    int    cycles = 0;
    string issue_test = "reset_values";

    // expected issue outputs, start at the reset values
    reg_idx_t   exp_a_sel = 4'd0;
    reg_idx_t   exp_b_sel = 4'd0;
    reg_idx_t   exp_w_sel = 4'd0;
    logic       exp_b_en = 1'b0;
    logic       exp_imm_en = 1'b0;
    logic       exp_wr = 1'b0;
    logic       exp_cpsr = 1'b0;
    barrel_op_e exp_barrel = lsl;
    word_t      exp_shift = 32'd0;
    alu_op_e    exp_alu = alu_mov;
    word_t      exp_imm = 32'hffff_ffff;

    tb_clock_gen u_clock (
        .clk   (clk),
        .reset (reset)
    );

    control_unit DUT (
        .clk              (clk),
        .reset            (reset),
        .instr_in         (instr_in),
        .b_bus_in         (b_bus_in),
        .control_reset    (control_reset),
        .update_address   (update_address),
        .pc_write_en      (pc_write_en),
        .reg_read_a_sel   (reg_read_a_sel),
        .reg_read_b_sel   (reg_read_b_sel),
        .reg_write_sel    (reg_write_sel),
        .reg_read_b_en    (reg_read_b_en),
        .reg_write_en     (reg_write_en),
        .cpsr_write_en    (cpsr_write_en),
        .barrel_op_sel    (barrel_op_sel),
        .barrel_shift_val (barrel_shift_val),
        .alu_op_sel       (alu_op_sel),
        .immediate_value  (immediate_value),
        .imm_output_en    (imm_output_en)
    );

    task automatic abort_run();
        $display("test failed");
        $fatal(1);
    endtask

    task automatic check_val(input string test, input string sig,
                             input logic [31:0] exp, input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("ERR %s %s: expected %h, actual %h", test, sig, exp, act);
            abort_run();
        end
    endtask

    // random word of one of the five kinds
    function automatic word_t make_instr();
        word_t w;
        int    kind;
        w    = $urandom;
        kind = $urandom % 10;
        if (kind < 3)
        begin
            w[27:25] = 3'b000;              // immediate shift
            w[4]     = 1'b0;
            if ($urandom % 4 == 0)
                w[11:7] = 5'd0;             // rrx case
        end
        else if (kind < 5)
        begin
            w[27:25] = 3'b000;              // shift by rs
            w[4]     = 1'b1;
        end
        else if (kind < 7)
            w[27:25] = 3'b001;              // rotated imm8
        else if (kind < 9)
        begin
            w[27:25] = ($urandom % 2) ? 3'b010 : 3'b011;  // load/store
            w[4]     = 1'b0;
        end
        else
            w[27:25] = 3'b101;              // branch
        return w;
    endfunction

    function automatic barrel_op_e shift_from_type(input logic [1:0] t);
        case (t)
            2'b00:   return lsl;
            2'b01:   return lsr;
            2'b10:   return asr;
            default: return ror;
        endcase
    endfunction

    // expected outputs after one issue edge, straight from the decode rules
    task automatic model_issue(input word_t w, input word_t bbus);
        exp_wr   = 1'b0;
        exp_cpsr = 1'b0;
        if (w[27:26] == 2'b00)
        begin
            exp_a_sel = w[19:16];
            exp_b_sel = w[3:0];
            exp_w_sel = w[15:12];
            exp_alu   = alu_op_e'(w[24:21]);
            exp_wr    = 1'b1;
            exp_cpsr  = w[20];              // s bit
            if (w[25])
            begin
                issue_test = "imm_issue";
                exp_barrel = ror;
                exp_shift  = {27'd0, w[11:8], 1'b0};
                exp_imm    = {24'd0, w[7:0]};
                exp_b_en   = 1'b0;
                exp_imm_en = 1'b1;
            end
            else
            begin
                exp_barrel = shift_from_type(w[6:5]);
                exp_b_en   = 1'b1;
                exp_imm_en = 1'b0;
                if (w[4])
                begin
                    issue_test = "reg_shift_issue";
                    exp_shift  = bbus;      // rs value off the b bus
                end
                else
                begin
                    issue_test = "imm_shift_issue";
                    exp_shift  = {27'd0, w[11:7]};
                    if (w[11:7] == 5'd0)
                        exp_barrel = rrx;
                end
            end
        end
        else
            issue_test = "ls_branch_noop";  // everything holds
    endtask

    task automatic check_issue(input logic rs_cycle, input reg_idx_t rs);
        check_val(issue_test, "reg_read_a_sel", exp_a_sel, reg_read_a_sel);
        check_val(issue_test, "reg_write_sel", exp_w_sel, reg_write_sel);
        if (rs_cycle)
        begin
            check_val("reg_shift_rs_read", "reg_read_b_sel", rs, reg_read_b_sel);
            check_val("reg_shift_rs_read", "reg_read_b_en", 1'b1, reg_read_b_en);
        end
        else
        begin
            check_val(issue_test, "reg_read_b_sel", exp_b_sel, reg_read_b_sel);
            check_val(issue_test, "reg_read_b_en", exp_b_en, reg_read_b_en);
        end
        check_val(issue_test, "reg_write_en", exp_wr, reg_write_en);
        check_val(issue_test, "cpsr_write_en", exp_cpsr, cpsr_write_en);
        check_val(issue_test, "barrel_op_sel", exp_barrel, barrel_op_sel);
        check_val(issue_test, "barrel_shift_val", exp_shift, barrel_shift_val);
        check_val(issue_test, "alu_op_sel", exp_alu, alu_op_sel);
        check_val(issue_test, "immediate_value", exp_imm, immediate_value);
        check_val(issue_test, "imm_output_en", exp_imm_en, imm_output_en);
    endtask

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit)
        begin
            $display("timeout: run still going after %0d cycles", cycles);
            abort_run();
        end
    end

    // all strobes and enables quiet while reset is high
    always @(negedge clk)
    begin
        if (reset && cycles > 0)
        begin
            check_val("reset", "control_reset", 1'b0, control_reset);
            check_val("reset", "update_address", 1'b0, update_address);
            check_val("reset", "pc_write_en", 1'b0, pc_write_en);
            check_val("reset", "reg_write_en", 1'b0, reg_write_en);
            check_val("reset", "cpsr_write_en", 1'b0, cpsr_write_en);
            check_val("reset", "reg_read_b_en", 1'b0, reg_read_b_en);
            check_val("reset", "imm_output_en", 1'b0, imm_output_en);
        end
    end

    initial
    begin
        int    seed_val;
        int    phase;
        logic  rs_cycle;
        word_t w;
        instr_in = nop_instr;
        b_bus_in = 32'd0;
        seed_val = $urandom(32'hd9ca);      // one seed for the whole run
        for (int n = 0; n < num_instr; n++)
            instr_list[n] = make_instr();
        instr_list[num_instr] = nop_instr;
        @(negedge reset);
        // j counts rising edges from e0, checks sit on the falling edge after ej
        for (int j = 0; j <= 3 * num_instr + 1; j++)
        begin
            @(negedge clk);
            phase = (j >= 1) ? (j - 1) % 3 : -1;  // 0 fetch, 1 decode, 2 execute
            check_val("reset_release", "control_reset", j == 0, control_reset);
            check_val("fetch_strobes", "update_address", phase == 1, update_address);
            check_val("fetch_strobes", "pc_write_en", phase == 1, pc_write_en);
            if (phase == 0 && j >= 4)
                model_issue(instr_list[(j - 4) / 3], bbus_list[(j - 4) / 3]);
            else
            begin
                exp_wr   = 1'b0;
                exp_cpsr = 1'b0;
            end
            w        = (phase == 2) ? instr_list[(j - 3) / 3] : nop_instr;
            rs_cycle = (phase == 2) && (w[27:25] == 3'b000) && w[4];
            check_issue(rs_cycle, w[11:8]);
            // next inputs
            if (phase == 0)
                instr_in = instr_list[(j - 1) / 3];
            if (phase == 2)
            begin
                bbus_list[(j - 3) / 3] = $urandom;
                b_bus_in = bbus_list[(j - 3) / 3];
            end
        end
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tb_clock_gen.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_clock_gen
(
    output logic clk,
    output logic reset
);

    localparam int half_period  = 5;   // 10 ns clock
    localparam int reset_cycles = 16;

    initial
    begin
        clk = 1'b0;
        forever #half_period clk = ~clk;
    end

    // reset held for 16 rising edges, dropped on a falling edge
    initial
    begin
        reset = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
    end

endmodule

`default_nettype wire

// ==== control_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module control_unit
    import arm_isa_pkg::*;
    import ctrl_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    input  wire word_t instr_in,
    input  wire word_t b_bus_in,
    output logic       control_reset,
    output logic       update_address,
    output logic       pc_write_en,
    output reg_idx_t   reg_read_a_sel,
    output reg_idx_t   reg_read_b_sel,
    output reg_idx_t   reg_write_sel,
    output logic       reg_read_b_en,
    output logic       reg_write_en,
    output logic       cpsr_write_en,
    output barrel_op_e barrel_op_sel,
    output word_t      barrel_shift_val,
    output alu_op_e    alu_op_sel,
    output word_t      immediate_value,
    output logic       imm_output_en
);

    seq_state_e state;

    // decode to issue bundle
    logic       dec_valid;
    reg_idx_t   dec_rn;
    reg_idx_t   dec_rm;
    reg_idx_t   dec_rd;
    reg_idx_t   dec_rs;
    logic       dec_reg_shift;
    alu_op_e    dec_alu_op;
    barrel_op_e dec_barrel_op;
    word_t      dec_shift_amt;
    logic       dec_use_imm;
    word_t      dec_imm;
    logic       dec_s_bit;

    ctrl_sequencer u_sequencer (
        .clk            (clk),
        .reset          (reset),
        .state          (state),
        .control_reset  (control_reset),
        .update_address (update_address),
        .pc_write_en    (pc_write_en)
    );

    instr_decoder u_decoder (
        .clk           (clk),
        .reset         (reset),
        .state         (state),
        .instr_in      (instr_in),
        .dec_valid     (dec_valid),
        .dec_rn        (dec_rn),
        .dec_rm        (dec_rm),
        .dec_rd        (dec_rd),
        .dec_rs        (dec_rs),
        .dec_reg_shift (dec_reg_shift),
        .dec_alu_op    (dec_alu_op),
        .dec_barrel_op (dec_barrel_op),
        .dec_shift_amt (dec_shift_amt),
        .dec_use_imm   (dec_use_imm),
        .dec_imm       (dec_imm),
        .dec_s_bit     (dec_s_bit)
    );

    issue_stage u_issue (
        .clk              (clk),
        .reset            (reset),
        .state            (state),
        .dec_valid        (dec_valid),
        .dec_rn           (dec_rn),
        .dec_rm           (dec_rm),
        .dec_rd           (dec_rd),
        .dec_rs           (dec_rs),
        .dec_reg_shift    (dec_reg_shift),
        .dec_alu_op       (dec_alu_op),
        .dec_barrel_op    (dec_barrel_op),
        .dec_shift_amt    (dec_shift_amt),
        .dec_use_imm      (dec_use_imm),
        .dec_imm          (dec_imm),
        .dec_s_bit        (dec_s_bit),
        .b_bus_in         (b_bus_in),
        .reg_read_a_sel   (reg_read_a_sel),
        .reg_read_b_sel   (reg_read_b_sel),
        .reg_write_sel    (reg_write_sel),
        .reg_read_b_en    (reg_read_b_en),
        .reg_write_en     (reg_write_en),
        .cpsr_write_en    (cpsr_write_en),
        .barrel_op_sel    (barrel_op_sel),
        .barrel_shift_val (barrel_shift_val),
        .alu_op_sel       (alu_op_sel),
        .immediate_value  (immediate_value),
        .imm_output_en    (imm_output_en)
    );

endmodule

`default_nettype wire

// ==== issue_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

module issue_stage
    import arm_isa_pkg::*;
    import ctrl_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire seq_state_e state,
    input  wire             dec_valid,
    input  wire reg_idx_t   dec_rn,
    input  wire reg_idx_t   dec_rm,
    input  wire reg_idx_t   dec_rd,
    input  wire reg_idx_t   dec_rs,
    input  wire             dec_reg_shift,
    input  wire alu_op_e    dec_alu_op,
    input  wire barrel_op_e dec_barrel_op,
    input  wire word_t      dec_shift_amt,
    input  wire             dec_use_imm,
    input  wire word_t      dec_imm,
    input  wire             dec_s_bit,
    input  wire word_t      b_bus_in,        // rs value during execute
    output reg_idx_t        reg_read_a_sel,
    output reg_idx_t        reg_read_b_sel,
    output reg_idx_t        reg_write_sel,
    output logic            reg_read_b_en,
    output logic            reg_write_en,
    output logic            cpsr_write_en,
    output barrel_op_e      barrel_op_sel,
    output word_t           barrel_shift_val,
    output alu_op_e         alu_op_sel,
    output word_t           immediate_value,
    output logic            imm_output_en
);

    reg_idx_t b_sel_q;  // issued b select, rm
    logic     b_en_q;   // issued register b bus enable
    logic     rs_read;  // rs on the b port this cycle

    // reg shift borrows the b port during execute to fetch rs
    assign rs_read = (state == execute) && dec_valid && dec_reg_shift;

    assign reg_read_b_sel = rs_read ? dec_rs : b_sel_q;
    assign reg_read_b_en  = rs_read | b_en_q;

    // operands and ops, held until the next valid issue
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reg_read_a_sel   <= rst_reg_sel;
            b_sel_q          <= rst_reg_sel;
            reg_write_sel    <= rst_reg_sel;
            alu_op_sel       <= rst_alu_op;
            barrel_op_sel    <= rst_barrel_op;
            barrel_shift_val <= rst_shift_val;
            immediate_value  <= rst_imm_value;
            b_en_q           <= 1'b0;
            imm_output_en    <= 1'b0;
        end
        else if (state == execute && dec_valid)
        begin
            reg_read_a_sel <= dec_rn;
            b_sel_q        <= dec_rm;
            reg_write_sel  <= dec_rd;
            alu_op_sel     <= dec_alu_op;
            barrel_op_sel  <= dec_barrel_op;
            if (dec_reg_shift)
                barrel_shift_val <= b_bus_in;       // rs read back off the b bus
            else
                barrel_shift_val <= dec_shift_amt;
            if (dec_use_imm)
                immediate_value <= dec_imm;         // kept otherwise
            b_en_q        <= ~dec_use_imm;          // b source, regs or immediate
            imm_output_en <= dec_use_imm;
        end
    end

    // write strobes, one cycle per issue
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            reg_write_en  <= 1'b0;
            cpsr_write_en <= 1'b0;
        end
        else if (state == execute)
        begin
            reg_write_en  <= dec_valid;              // no-op for ld/st and branch
            cpsr_write_en <= dec_valid & dec_s_bit;
        end
        else
        begin
            reg_write_en  <= 1'b0;  // dropped again after fetch
            cpsr_write_en <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== instr_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none

module instr_decoder
    import arm_isa_pkg::*;
    import ctrl_pkg::*;
(
    input  wire             clk,
    input  wire             reset,
    input  wire seq_state_e state,
    input  wire word_t      instr_in,       // sampled at end of fetch
    output logic            dec_valid,      // data processing word decoded
    output reg_idx_t        dec_rn,
    output reg_idx_t        dec_rm,
    output reg_idx_t        dec_rd,
    output reg_idx_t        dec_rs,
    output logic            dec_reg_shift,  // amount comes from rs
    output alu_op_e         dec_alu_op,
    output barrel_op_e      dec_barrel_op,
    output word_t           dec_shift_amt,  // don't care for reg shift
    output logic            dec_use_imm,    // b operand is the immediate
    output word_t           dec_imm,
    output logic            dec_s_bit
);

    word_t        ir;           // fetch-decode instruction register
    instr_class_e instr_class;
    logic         is_dp;
    logic [4:0]   shamt;
    logic [3:0]   rot;

    barrel_op_e   barrel_op_nxt;
    word_t        shift_amt_nxt;
    logic         use_imm_nxt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ir <= nop_instr;
        end
        else if (state == fetch)
        begin
            ir <= instr_in;
        end
    end

    // class from bits 27:25 plus bit 4
    assign instr_class = instr_class_e'({ir[class_lo +: 3], ir[class_tag_bit]});
    assign is_dp       = instr_class inside {dp_imm_shift, dp_reg_shift, dp_imm_a, dp_imm_b};

    assign shamt = ir[shamt_lo +: 5];
    assign rot   = ir[rot_lo +: 4];

    // shifter setup per encoding
    always_comb
    begin
        barrel_op_nxt = lsl;
        shift_amt_nxt = 32'd0;
        use_imm_nxt   = 1'b0;
        case (instr_class)
            dp_imm_shift:
            begin
                // zero amount means rrx here, type bits ignored
                if (shamt == 5'd0)
                    barrel_op_nxt = rrx;
                else
                    barrel_op_nxt = barrel_op_e'({1'b0, ir[shift_type_lo +: 2]});
                shift_amt_nxt = {27'd0, shamt};
            end
            dp_reg_shift:
            begin
                barrel_op_nxt = barrel_op_e'({1'b0, ir[shift_type_lo +: 2]});  // never rrx
            end
            dp_imm_a, dp_imm_b:
            begin
                barrel_op_nxt = ror;
                shift_amt_nxt = {27'd0, rot, 1'b0};  // rotate field times two
                use_imm_nxt   = 1'b1;
            end
            default:
            begin
                barrel_op_nxt = lsl;  // load/store, branch: issue ignores it
            end
        endcase
    end

    // control part of the bundle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            dec_valid     <= 1'b0;
            dec_reg_shift <= 1'b0;
        end
        else if (state == decode)
        begin
            dec_valid     <= is_dp;
            dec_reg_shift <= (instr_class == dp_reg_shift);
        end
    end

    // payload, only looked at when dec_valid
    always_ff @(posedge clk)
    begin
        if (state == decode)
        begin
            dec_rn        <= ir[rn_lo +: 4];
            dec_rm        <= ir[rm_lo +: 4];
            dec_rd        <= ir[rd_lo +: 4];
            dec_rs        <= ir[rs_lo +: 4];
            dec_alu_op    <= alu_op_e'(ir[alu_op_lo +: 4]);
            dec_s_bit     <= ir[s_bit_pos];     // flags update
            dec_barrel_op <= barrel_op_nxt;
            dec_shift_amt <= shift_amt_nxt;
            dec_use_imm   <= use_imm_nxt;
            dec_imm       <= {24'd0, ir[imm8_lo +: 8]};  // zero extended imm8
        end
    end

endmodule

`default_nettype wire

// ==== ctrl_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module ctrl_sequencer
    import ctrl_pkg::*;
(
    input  wire        clk,
    input  wire        reset,
    output seq_state_e state,
    output logic       control_reset,   // register bank reset, one cycle after release
    output logic       update_address,  // address register loads incrementer
    output logic       pc_write_en      // pc takes incremented address
);

    seq_state_e state_nxt;

    // fixed stepping order
    always_comb
    begin
        case (state)
            reset_hold:    state_nxt = reset_release;
            reset_release: state_nxt = fetch;
            fetch:         state_nxt = decode;
            decode:        state_nxt = execute;
            execute:       state_nxt = fetch;   // back for the next word
            default:       state_nxt = reset_hold;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= reset_hold;
        end
        else
        begin
            state <= state_nxt;
        end
    end

    // one-cycle pulse on the first edge after release
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            control_reset <= 1'b0;
        end
        else
        begin
            control_reset <= (state == reset_hold);
        end
    end

    // no branches taken,
    // so every fetch bumps the address and writes the pc
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            update_address <= 1'b0;
            pc_write_en    <= 1'b0;
        end
        else
        begin
            update_address <= (state == fetch);  // high the cycle after the fetch edge
            pc_write_en    <= (state == fetch);
        end
    end

endmodule

`default_nettype wire

// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

    // sequencer order is fixed, fetch/decode/execute loops forever
    typedef enum logic [2:0] {
        reset_hold    = 3'd0,  // sits here while reset is high
        reset_release = 3'd1,  // single cycle, control_reset pulse
        fetch         = 3'd2,
        decode        = 3'd3,
        execute       = 3'd4
    } seq_state_e;

    // issue outputs out of reset
    localparam arm_isa_pkg::reg_idx_t   rst_reg_sel   = 4'd0;  // r0
    localparam arm_isa_pkg::alu_op_e    rst_alu_op    = arm_isa_pkg::alu_mov;
    localparam arm_isa_pkg::barrel_op_e rst_barrel_op = arm_isa_pkg::lsl;
    localparam arm_isa_pkg::word_t      rst_shift_val = 32'd0;         // lsl #0, pass through
    localparam arm_isa_pkg::word_t      rst_imm_value = 32'hffff_ffff;

endpackage

`default_nettype wire

// ==== arm_isa_pkg.sv ====
`default_nettype none

package arm_isa_pkg;

    typedef logic [31:0] word_t;     // one data word
    typedef logic [3:0]  reg_idx_t;  // register bank index, r0..r15

    // class code is {instr[27:25], instr[4]}
    typedef enum logic [3:0] {
        dp_imm_shift = 4'b0000,  // data processing, immediate shift
        dp_reg_shift = 4'b0001,  // data processing, shift by rs
        dp_imm_a     = 4'b0010,  // rotated imm8, bit 4 low
        dp_imm_b     = 4'b0011,  // rotated imm8, bit 4 high
        ls_imm_a     = 4'b0100,  // load/store imm offset
        ls_imm_b     = 4'b0101,
        ls_reg       = 4'b0110,  // load/store reg offset
        branch_a     = 4'b1010,  // b / bl
        branch_b     = 4'b1011
    } instr_class_e;

    // arm opcode order, bits 24:21
    typedef enum logic [3:0] {
        alu_and = 4'h0,
        alu_eor = 4'h1,
        alu_sub = 4'h2,
        alu_rsb = 4'h3,  // reverse subtract
        alu_add = 4'h4,
        alu_adc = 4'h5,
        alu_sbc = 4'h6,
        alu_rsc = 4'h7,
        alu_tst = 4'h8,  // flags only
        alu_teq = 4'h9,
        alu_cmp = 4'ha,
        alu_cmn = 4'hb,
        alu_orr = 4'hc,
        alu_mov = 4'hd,
        alu_bic = 4'he,  // bit clear
        alu_mvn = 4'hf
    } alu_op_e;

    typedef enum logic [2:0] {
        lsl = 3'd0,  // low two bits match instr[6:5]
        lsr = 3'd1,
        asr = 3'd2,
        ror = 3'd3,
        rrx = 3'd4   // rotate right through carry
    } barrel_op_e;

    localparam word_t nop_instr = 32'he1a0_0000;  // mov r0, r0, cond al

    // instruction field positions
    localparam int class_lo      = 25;  // bits 27:25
    localparam int class_tag_bit = 4;   // splits imm shift from reg shift
    localparam int alu_op_lo     = 21;  // bits 24:21
    localparam int s_bit_pos     = 20;
    localparam int rn_lo         = 16;
    localparam int rd_lo         = 12;
    localparam int rs_lo         = 8;
    localparam int rm_lo         = 0;
    localparam int shamt_lo      = 7;   // bits 11:7
    localparam int shift_type_lo = 5;   // bits 6:5
    localparam int rot_lo        = 8;   // rotate field, bits 11:8
    localparam int imm8_lo       = 0;

endpackage

`default_nettype wire
